// ==== common/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

  // full address on the external bus.
  typedef logic [3:0] wb_adr_t;

  // bus data, one byte wide.
  typedef logic [7:0] wb_dat_t;

  typedef logic [2:0] slave_adr_t; // register offset inside a slave.

  // address bit that selects the uptime counter over the misc block.
  localparam int unsigned UPTIME_SEL_BIT = 3;

endpackage

`default_nettype wire

// ==== common/board_ctrl_pkg.sv ====
`default_nettype none

package board_ctrl_pkg;

  // misc block register map.
  localparam wb_bus_pkg::slave_adr_t REG_MISC_RESET       = 3'd0;
  localparam wb_bus_pkg::slave_adr_t REG_MISC_SYSCONFIG_0 = 3'd1;
  localparam wb_bus_pkg::slave_adr_t REG_MISC_SYSCONFIG_1 = 3'd2;
  localparam wb_bus_pkg::slave_adr_t REG_MISC_SELECTMAP   = 3'd3; // reserved.
  localparam wb_bus_pkg::slave_adr_t REG_MISC_FLASH       = 3'd4;
  localparam wb_bus_pkg::slave_adr_t REG_MISC_REGS        = 3'd5;

  typedef logic [7:0] sys_config_t; // board configuration byte.
  typedef logic [3:0] dip_t;
  typedef logic [1:0] led_t;

  // uptime counter byte lanes.
  localparam wb_bus_pkg::slave_adr_t UPT_BYTE0 = 3'd0;
  localparam wb_bus_pkg::slave_adr_t UPT_BYTE1 = 3'd1;
  localparam wb_bus_pkg::slave_adr_t UPT_BYTE2 = 3'd2;
  localparam wb_bus_pkg::slave_adr_t UPT_BYTE3 = 3'd3;

  typedef logic [31:0] uptime_t;

endpackage

`default_nettype wire

// ==== misc/input_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module input_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                        wb_clk_i,
  input  wire logic                        wb_rst_i,
  input  wire board_ctrl_pkg::sys_config_t sys_config_i,
  input  wire board_ctrl_pkg::dip_t        user_dip_i,
  input  wire board_ctrl_pkg::dip_t        config_dip_i,
  input  wire logic                        flash_busy_n_i,
  output board_ctrl_pkg::sys_config_t      sys_config_o,
  output board_ctrl_pkg::dip_t             user_dip_o,
  output board_ctrl_pkg::dip_t             config_dip_o,
  output logic                             flash_busy_n_o
);

  localparam int W = 17;
  localparam logic [W-1:0] RST_VAL = {1'b1, 16'h0000}; // busy_n idles high.

  logic [W-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= RST_VAL;
      end
    end else begin
      sync_q[0] <= {flash_busy_n_i, config_dip_i, user_dip_i, sys_config_i};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign {flash_busy_n_o, config_dip_o, user_dip_o, sys_config_o} = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== misc/misc_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module misc_regs #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                        wb_clk_i,
  input  wire logic                        wb_rst_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_we_i,
  input  wire wb_bus_pkg::slave_adr_t      wb_adr_i,
  input  wire wb_bus_pkg::wb_dat_t         wb_dat_i,
  output wb_bus_pkg::wb_dat_t              wb_dat_o,
  output logic                             wb_ack_o,

  input  wire board_ctrl_pkg::sys_config_t sys_config_i,
  input  wire board_ctrl_pkg::dip_t        user_dip_i,
  input  wire board_ctrl_pkg::dip_t        config_dip_i,
  input  wire logic                        flash_busy_n_i,

  output logic                             por_force_o,
  output logic                             geth_reset_req_o,
  output board_ctrl_pkg::led_t             user_led_o
);

  board_ctrl_pkg::sys_config_t sys_config_s;
  board_ctrl_pkg::dip_t        user_dip_s;
  board_ctrl_pkg::dip_t        config_dip_s;
  logic                        flash_busy_n_s;
  logic                        wb_trans;

  input_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) input_sync_inst (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .sys_config_i   (sys_config_i),
    .user_dip_i     (user_dip_i),
    .config_dip_i   (config_dip_i),
    .flash_busy_n_i (flash_busy_n_i),
    .sys_config_o   (sys_config_s),
    .user_dip_o     (user_dip_s),
    .config_dip_o   (config_dip_s),
    .flash_busy_n_o (flash_busy_n_s)
  );

  // new request only when no ack is pending.
  assign wb_trans = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_comb begin
    case (wb_adr_i)
      board_ctrl_pkg::REG_MISC_RESET:       wb_dat_o = {6'b0, geth_reset_req_o, por_force_o};
      board_ctrl_pkg::REG_MISC_SYSCONFIG_0: wb_dat_o = {config_dip_s, user_dip_s};
      board_ctrl_pkg::REG_MISC_SYSCONFIG_1: wb_dat_o = sys_config_s;
      board_ctrl_pkg::REG_MISC_SELECTMAP:   wb_dat_o = '0; // port not fitted.
      board_ctrl_pkg::REG_MISC_FLASH:       wb_dat_o = {7'b0, flash_busy_n_s};
      board_ctrl_pkg::REG_MISC_REGS:        wb_dat_o = {6'b0, user_led_o};
      default:                              wb_dat_o = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o         <= 1'b0;
      por_force_o      <= 1'b0;
      geth_reset_req_o <= 1'b0;
      user_led_o       <= '0;
    end else begin
      wb_ack_o <= wb_trans;
      if (wb_trans && wb_we_i) begin
        case (wb_adr_i)
          board_ctrl_pkg::REG_MISC_RESET: begin
            por_force_o      <= wb_dat_i[0];
            geth_reset_req_o <= wb_dat_i[1];
          end
          board_ctrl_pkg::REG_MISC_REGS: user_led_o <= wb_dat_i[1:0];
          default: ; // status and reserved offsets.
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/uptime_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module uptime_counter (
  input  wire logic                   wb_clk_i,
  input  wire logic                   wb_rst_i,
  input  wire logic                   wb_stb_i,
  input  wire logic                   wb_cyc_i,
  input  wire logic                   wb_we_i,
  input  wire wb_bus_pkg::slave_adr_t wb_adr_i,
  output wb_bus_pkg::wb_dat_t         wb_dat_o,
  output logic                        wb_ack_o
);

  board_ctrl_pkg::uptime_t count_q;
  logic [23:0]             shadow_q; // upper bytes of the last snapshot.
  logic                    wb_trans;

  assign wb_trans = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count_q  <= '0;
      wb_ack_o <= 1'b0;
    end else begin
      count_q  <= count_q + 32'd1;
      wb_ack_o <= wb_trans; // writes are acked and dropped.
    end
  end

  // read data is registered so byte 0 and the shadow come from one sample.
  always_ff @(posedge wb_clk_i) begin
    if (wb_trans && !wb_we_i) begin
      case (wb_adr_i)
        board_ctrl_pkg::UPT_BYTE0: begin
          wb_dat_o <= count_q[7:0];
          shadow_q <= count_q[31:8];
        end
        board_ctrl_pkg::UPT_BYTE1: wb_dat_o <= shadow_q[7:0];
        board_ctrl_pkg::UPT_BYTE2: wb_dat_o <= shadow_q[15:8];
        board_ctrl_pkg::UPT_BYTE3: wb_dat_o <= shadow_q[23:16];
        default:                   wb_dat_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/wb_slave_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_slave_mux (
  input  wire logic                wb_stb_i,
  input  wire wb_bus_pkg::wb_adr_t wb_adr_i,

  input  wire wb_bus_pkg::wb_dat_t misc_dat_i,
  input  wire logic                misc_ack_i,
  input  wire wb_bus_pkg::wb_dat_t upt_dat_i,
  input  wire logic                upt_ack_i,

  output logic                     misc_stb_o,
  output logic                     upt_stb_o,
  output wb_bus_pkg::wb_dat_t      wb_dat_o,
  output logic                     wb_ack_o
);

  logic upt_sel;

  assign upt_sel = wb_adr_i[wb_bus_pkg::UPTIME_SEL_BIT];

  assign misc_stb_o = wb_stb_i && !upt_sel;
  assign upt_stb_o  = wb_stb_i && upt_sel;

  // only the strobed slave can ack.
  assign wb_ack_o = misc_ack_i || upt_ack_i;
  assign wb_dat_o = upt_sel ? upt_dat_i : misc_dat_i;

endmodule

`default_nettype wire

// ==== design/reset_stretch.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_stretch #(
  parameter int RST_HOLD = 16
) (
  input  wire logic wb_clk_i,
  input  wire logic wb_rst_i,
  input  wire logic rst_req_i,
  output logic      rst_o
);

  localparam int CNT_W = $clog2(RST_HOLD + 1);
  // one hold cycle is spent on the edge that sees the request drop.
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(RST_HOLD - 1);

  logic [CNT_W-1:0] hold_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      hold_q <= '0;
      rst_o  <= 1'b0;
    end else begin
      rst_o <= rst_req_i || (hold_q != '0);
      if (rst_req_i) begin
        hold_q <= RELOAD; // restarts on every re-set.
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sys_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_top #(
  parameter int SYNC_STAGES = 2,
  parameter int RST_HOLD    = 16
) (
  input  wire logic                        wb_clk_i,
  input  wire logic                        wb_rst_i,
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire wb_bus_pkg::wb_adr_t         wb_adr_i,
  input  wire wb_bus_pkg::wb_dat_t         wb_dat_i,
  output wb_bus_pkg::wb_dat_t              wb_dat_o,
  output logic                             wb_ack_o,

  input  wire board_ctrl_pkg::sys_config_t sys_config_i,
  input  wire board_ctrl_pkg::dip_t        user_dip_i,
  input  wire board_ctrl_pkg::dip_t        config_dip_i,
  input  wire logic                        flash_busy_n_i,
  output logic                             por_force_o,
  output logic                             geth_reset_o,
  output board_ctrl_pkg::led_t             user_led_o
);

  logic                misc_stb;
  logic                misc_ack;
  wb_bus_pkg::wb_dat_t misc_dat;
  logic                upt_stb;
  logic                upt_ack;
  wb_bus_pkg::wb_dat_t upt_dat;
  logic                geth_reset_req;

  wb_slave_mux wb_slave_mux_inst (
    .wb_stb_i   (wb_stb_i),
    .wb_adr_i   (wb_adr_i),
    .misc_dat_i (misc_dat),
    .misc_ack_i (misc_ack),
    .upt_dat_i  (upt_dat),
    .upt_ack_i  (upt_ack),
    .misc_stb_o (misc_stb),
    .upt_stb_o  (upt_stb),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o)
  );

  misc_regs #(
    .SYNC_STAGES (SYNC_STAGES)
  ) misc_regs_inst (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .wb_stb_i         (misc_stb),
    .wb_cyc_i         (wb_cyc_i),
    .wb_we_i          (wb_we_i),
    .wb_adr_i         (wb_adr_i[2:0]),
    .wb_dat_i         (wb_dat_i),
    .wb_dat_o         (misc_dat),
    .wb_ack_o         (misc_ack),
    .sys_config_i     (sys_config_i),
    .user_dip_i       (user_dip_i),
    .config_dip_i     (config_dip_i),
    .flash_busy_n_i   (flash_busy_n_i),
    .por_force_o      (por_force_o),
    .geth_reset_req_o (geth_reset_req),
    .user_led_o       (user_led_o)
  );

  uptime_counter uptime_counter_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_stb_i (upt_stb),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i[2:0]),
    .wb_dat_o (upt_dat),
    .wb_ack_o (upt_ack)
  );

  reset_stretch #(
    .RST_HOLD (RST_HOLD)
  ) reset_stretch_inst (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .rst_req_i (geth_reset_req),
    .rst_o     (geth_reset_o)
  );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release lines up with the stimulus delay.
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/sys_ctrl_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_asserts #(
  parameter int RST_HOLD = 16
) (
  input wire logic wb_clk_i,
  input wire logic wb_rst_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_i,
  input wire logic geth_reset_req_i,
  input wire logic geth_reset_i
);

  int unsigned low_cycles; // cycles since the request dropped.

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || geth_reset_req_i) begin
      low_cycles <= 0;
    end else if (low_cycles < RST_HOLD) begin
      low_cycles <= low_cycles + 1;
    end
  end

  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("acknowledge high for two cycles in a row");

  ack_follows_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> wb_ack_i)
    else $error("no acknowledge one cycle after the strobe");

  ack_has_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
    else $error("acknowledge without a preceding strobe");

  geth_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $fell(geth_reset_i) |-> (low_cycles >= RST_HOLD))
    else $error("ethernet reset released before the hold time");

endmodule

bind sys_ctrl_top sys_ctrl_asserts #(
  .RST_HOLD (RST_HOLD)
) sys_ctrl_asserts_inst (
  .wb_clk_i         (wb_clk_i),
  .wb_rst_i         (wb_rst_i),
  .wb_cyc_i         (wb_cyc_i),
  .wb_stb_i         (wb_stb_i),
  .wb_ack_i         (wb_ack_o),
  .geth_reset_req_i (geth_reset_req),
  .geth_reset_i     (geth_reset_o)
);

`default_nettype wire

// ==== bench/sys_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_tb;

  localparam int SYNC_STAGES = 2;
  localparam int RST_HOLD    = 16;
  localparam int CLK_PERIOD  = 4;
  localparam int ROUNDS      = 8;
  localparam int ACK_LIMIT   = 8;
  localparam int HOLD_EDGES  = 6;
  // about three cycles per bus access, plus the waits of each test.
  localparam int BUDGET = 3 * (2 + ROUNDS * 19 + 20) + ROUNDS * (SYNC_STAGES + 2)
                          + 2 * RST_HOLD + HOLD_EDGES + 40;

  logic                        wb_clk;
  logic                        wb_rst;
  logic                        wb_cyc, wb_stb, wb_we, wb_ack;
  wb_bus_pkg::wb_adr_t         wb_adr;
  wb_bus_pkg::wb_dat_t         wb_dat_w, wb_dat_r;
  board_ctrl_pkg::sys_config_t sys_config;
  board_ctrl_pkg::dip_t        user_dip, config_dip;
  logic                        flash_busy_n, por_force, geth_reset;
  board_ctrl_pkg::led_t        user_led;

  // reference model state.
  logic                        m_por, m_geth_req, m_busy_n;
  board_ctrl_pkg::led_t        m_led;
  board_ctrl_pkg::sys_config_t m_sys_config;
  board_ctrl_pkg::dip_t        m_user_dip, m_config_dip;

  logic [31:0]         lfsr_q = 32'd97946;
  int unsigned         cycle_count, ack_cycle;
  int                  test_errors, tests_passed, tests_failed;
  wb_bus_pkg::wb_dat_t exp_q[$], got_q[$];
  string               name_q[$];
  time                 time_q[$];

  clk_gen #(
    .PERIOD     (CLK_PERIOD),
    .RST_CYCLES (2)
  ) clk_gen_inst (
    .clk_o (wb_clk),
    .rst_o (wb_rst)
  );

  sys_ctrl_top #(
    .SYNC_STAGES (SYNC_STAGES),
    .RST_HOLD    (RST_HOLD)
  ) sys_ctrl_top_inst (
    .wb_clk_i       (wb_clk),
    .wb_rst_i       (wb_rst),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .wb_dat_o       (wb_dat_r),
    .wb_ack_o       (wb_ack),
    .sys_config_i   (sys_config),
    .user_dip_i     (user_dip),
    .config_dip_i   (config_dip),
    .flash_busy_n_i (flash_busy_n),
    .por_force_o    (por_force),
    .geth_reset_o   (geth_reset),
    .user_led_o     (user_led)
  );

  always @(posedge wb_clk) begin
    if (wb_rst) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic wb_bus_pkg::wb_dat_t expected_misc(input wb_bus_pkg::slave_adr_t off);
    case (off)
      board_ctrl_pkg::REG_MISC_RESET:       return {6'b0, m_geth_req, m_por};
      board_ctrl_pkg::REG_MISC_SYSCONFIG_0: return {m_config_dip, m_user_dip};
      board_ctrl_pkg::REG_MISC_SYSCONFIG_1: return m_sys_config;
      board_ctrl_pkg::REG_MISC_FLASH:       return {7'b0, m_busy_n};
      board_ctrl_pkg::REG_MISC_REGS:        return {6'b0, m_led};
      default:                              return 8'h00;
    endcase
  endfunction

  task automatic report_mismatch(input time t, input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("mismatch at %0t ns: %s expected %h, got %h", t, name, exp, got);
    test_errors++;
  endtask

  task automatic bus_cycle(input logic we, input wb_bus_pkg::wb_adr_t adr,
                           input wb_bus_pkg::wb_dat_t wdat, output wb_bus_pkg::wb_dat_t rdat);
    int waited;
    @(posedge wb_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    do begin
      @(posedge wb_clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      $display("at %0t ns: no acknowledge for the access to address %h", $time, adr);
      test_errors++;
    end
    rdat      = wb_dat_r;
    ack_cycle = cycle_count;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
  endtask

  task automatic write_reg(input wb_bus_pkg::wb_adr_t adr, input wb_bus_pkg::wb_dat_t d);
    wb_bus_pkg::wb_dat_t unused;
    bus_cycle(1'b1, adr, d, unused);
    if (!adr[wb_bus_pkg::UPTIME_SEL_BIT]) begin
      case (adr[2:0])
        board_ctrl_pkg::REG_MISC_RESET: begin
          m_por      = d[0];
          m_geth_req = d[1];
        end
        board_ctrl_pkg::REG_MISC_REGS: m_led = d[1:0];
        default: ;
      endcase
    end
  endtask

  // queued for the compare process.
  task automatic check_read(input wb_bus_pkg::wb_adr_t adr, input wb_bus_pkg::wb_dat_t exp);
    wb_bus_pkg::wb_dat_t got;
    bus_cycle(1'b0, adr, 8'h00, got);
    exp_q.push_back(exp);
    name_q.push_back($sformatf("wb_dat_o at address %h", adr));
    time_q.push_back($time);
    got_q.push_back(got);
  endtask

  always begin
    wait (got_q.size() != 0);
    if (got_q[0] !== exp_q[0]) begin
      report_mismatch(time_q[0], name_q[0], exp_q[0], got_q[0]);
    end
    void'(exp_q.pop_front());
    void'(name_q.pop_front());
    void'(time_q.pop_front());
    void'(got_q.pop_front());
  end

  task automatic read_uptime(output logic [31:0] value, output int unsigned at_cycle);
    wb_bus_pkg::wb_dat_t b;
    value    = '0;
    at_cycle = 0;
    for (int i = 0; i < 4; i++) begin
      bus_cycle(1'b0, 4'(8 + i), 8'h00, b);
      if (i == 0) begin
        at_cycle = ack_cycle;
      end
      value[8*i +: 8] = b;
    end
  endtask

  task automatic end_test(input string name);
    wait (got_q.size() == 0);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin : stimulus
    wb_bus_pkg::wb_dat_t    d;
    wb_bus_pkg::slave_adr_t off;
    logic [31:0]            first, second;
    int unsigned            c1, c2;
    int                     held, acks, exp_acks;
    logic                   pending;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    sys_config   = '0;
    user_dip     = '0;
    config_dip   = '0;
    flash_busy_n = 1'b1;
    m_por        = 1'b0;
    m_geth_req   = 1'b0;
    m_led        = '0;
    m_sys_config = '0;
    m_user_dip   = '0;
    m_config_dip = '0;
    m_busy_n     = 1'b1;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (wb_rst === 1'b0);

    if (por_force !== 1'b0) report_mismatch($time, "por_force_o", 0, por_force);
    if (geth_reset !== 1'b0) report_mismatch($time, "geth_reset_o", 0, geth_reset);
    if (user_led !== 2'b00) report_mismatch($time, "user_led_o", 0, user_led);
    check_read(4'h0, expected_misc(3'd0));
    check_read(4'h5, expected_misc(3'd5));
    end_test("reset state");

    for (int r = 0; r < ROUNDS; r++) begin
      d = 8'(rand_bits(8));
      write_reg(4'h0, d);
      if (por_force !== d[0]) report_mismatch($time, "por_force_o", d[0], por_force);
      d = 8'(rand_bits(8));
      write_reg(4'h5, d);
      if (user_led !== d[1:0]) report_mismatch($time, "user_led_o", d[1:0], user_led);
      check_read(4'h0, expected_misc(3'd0));
      check_read(4'h5, expected_misc(3'd5));
      off = 3'(rand_bits(3));
      if (off == 3'd0 || off == 3'd5) off = off + 3'd1; // skip the writable ones.
      write_reg({1'b0, off}, 8'(rand_bits(8)));
      for (int a = 0; a < 8; a++) check_read(4'(a), expected_misc(3'(a)));
    end
    end_test("register round trip");

    for (int r = 0; r < ROUNDS; r++) begin
      @(posedge wb_clk);
      #1;
      sys_config   = 8'(rand_bits(8));
      user_dip     = 4'(rand_bits(4));
      config_dip   = 4'(rand_bits(4));
      flash_busy_n = 1'(rand_bits(1));
      repeat (SYNC_STAGES + 1) @(posedge wb_clk);
      m_sys_config = sys_config;
      m_user_dip   = user_dip;
      m_config_dip = config_dip;
      m_busy_n     = flash_busy_n;
      for (int a = 0; a < 8; a++) check_read(4'(a), expected_misc(3'(a)));
    end
    end_test("board input read-back");

    write_reg(4'h0, 8'h02);
    repeat (2) @(posedge wb_clk);
    #1;
    if (geth_reset !== 1'b1) report_mismatch($time, "geth_reset_o", 1, geth_reset);
    write_reg(4'h0, 8'h00);
    held = 0;
    // counted from the acknowledge cycle of the clearing write.
    while (geth_reset === 1'b1 && held <= RST_HOLD + 4) begin
      held++;
      @(posedge wb_clk);
      #1;
    end
    if (held != RST_HOLD) report_mismatch($time, "geth_reset_o high cycles", RST_HOLD, held);
    end_test("ethernet reset hold");

    read_uptime(first, c1);
    repeat (rand_bits(4)) @(posedge wb_clk);
    read_uptime(second, c2);
    if (second - first < c2 - c1) begin
      $display("mismatch at %0t ns: uptime delta expected at least %0d, got %0d",
               $time, c2 - c1, second - first);
      test_errors++;
    end
    for (int i = 1; i < 4; i++) begin
      bus_cycle(1'b0, 4'(8 + i), 8'h00, d);
      if (d !== second[8*i +: 8]) report_mismatch($time, "uptime byte", second[8*i +: 8], d);
    end
    check_read(4'hC, 8'h00);
    end_test("uptime snapshot");

    d = 8'(rand_bits(2));
    @(posedge wb_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = 4'h5;
    wb_dat_w = d;
    acks     = 0;
    exp_acks = 0;
    pending  = 1'b0;
    for (int e = 0; e < HOLD_EDGES; e++) begin
      @(posedge wb_clk);
      #1;
      // a held strobe starts a request only when no ack is pending.
      if (!pending) begin
        exp_acks++;
        pending = 1'b1;
      end else begin
        pending = 1'b0;
      end
      if (wb_ack) acks++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    m_led  = d[1:0];
    @(posedge wb_clk);
    #1;
    if (wb_ack) acks++;
    if (acks != exp_acks) report_mismatch($time, "wb_ack_o count", exp_acks, acks);
    check_read(4'h5, expected_misc(3'd5));
    end_test("single-ack guard");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(BUDGET * CLK_PERIOD * 4);
    $display("timeout: the tests did not finish within %0d ns", BUDGET * CLK_PERIOD * 4);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/wb_bus_pkg.sv
common/board_ctrl_pkg.sv
misc/input_sync.sv
misc/misc_regs.sv
design/uptime_counter.sv
design/wb_slave_mux.sv
design/reset_stretch.sv
design/sys_ctrl_top.sv
bench/clk_gen.sv
bench/sys_ctrl_asserts.sv
bench/sys_ctrl_tb.sv
